// File: common/zmap_settings.svh
`ifndef ZMAP_SETTINGS_SVH
`define ZMAP_SETTINGS_SVH

// 16 KB windows over the 64 KB CPU space
`define ZMAP_WINDOWS 4

// page ports #10AF..#13AF
`define ZMAP_PORT_LO 8'hAF
`define ZMAP_PORT_HI_BASE 8'h10

`define ZMAP_PAGE_W 8
`define ZMAP_DADDR_W 21     // 16-bit words, 4 MB

`endif

// File: common/zmap_pkg.sv
`include "zmap_settings.svh"

package zmap_pkg;

    typedef logic [15:0] zaddr_t;
    typedef logic [7:0] zdata_t;

    typedef logic [`ZMAP_PAGE_W-1:0] page_t;      // 16 KB units
    typedef logic [$clog2(`ZMAP_WINDOWS)-1:0] win_sel_t;

    typedef logic [`ZMAP_DADDR_W-1:0] daddr_t;
    typedef logic [1:0] bsel_t;                   // {high byte, low byte}

    // one start pulse per Z80 cycle
    typedef enum logic [1:0] {
        bus_idle,
        bus_io,
        bus_mem
    } bus_state_t;

endpackage

// File: common/zbus_if.sv
`timescale 1ns/100ps

interface zbus_if;

    zmap_pkg::zaddr_t a;    // sampled along with the strobes
    zmap_pkg::zdata_t d;

    logic rd;
    logic wr;

    logic iord;             // level, whole io read
    logic iowr_s;           // one-cycle start pulses
    logic mem_s;

    modport decoder (
        output a, d,
        output rd, wr,
        output iord, iowr_s, mem_s
    );

    modport client (
        input a, d,
        input rd, wr,
        input iord, iowr_s, mem_s
    );

endinterface

// File: design/zsignals.sv
`timescale 1ns/100ps

module zsignals (
    input  logic             fclk,
    input  logic             arst_n,
    input  logic             iorq_n,
    input  logic             mreq_n,
    input  logic             rd_n,
    input  logic             wr_n,
    input  zmap_pkg::zaddr_t a,
    input  zmap_pkg::zdata_t d_in,
    zbus_if.decoder          bus
);

    // {iorq, mreq, rd, wr}, active high
    logic [3:0] strb_s1;
    logic [3:0] strb_s2;

    zmap_pkg::zaddr_t a_s1;
    zmap_pkg::zaddr_t a_s2;
    zmap_pkg::zdata_t d_s1;
    zmap_pkg::zdata_t d_s2;

    zmap_pkg::bus_state_t state;
    logic iowr_s;
    logic mem_s;

    logic iorq;
    logic mreq;
    logic rd;
    logic wr;
    logic io_cond;
    logic mem_cond;

    always_ff @(posedge fclk or negedge arst_n) begin
        if (!arst_n) begin
            strb_s1 <= '0;
            strb_s2 <= '0;
        end else begin
            strb_s1 <= ~{iorq_n, mreq_n, rd_n, wr_n};
            strb_s2 <= strb_s1;
        end
    end

    // same two stages as the strobes
    always_ff @(posedge fclk) begin
        a_s1 <= a;
        a_s2 <= a_s1;
        d_s1 <= d_in;
        d_s2 <= d_s1;
    end

    assign iorq = strb_s2[3];
    assign mreq = strb_s2[2];
    assign rd   = strb_s2[1];
    assign wr   = strb_s2[0];

    assign io_cond  = iorq & (rd | wr);
    assign mem_cond = mreq & (rd | wr);

    always_ff @(posedge fclk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= zmap_pkg::bus_idle;
            iowr_s <= 1'b0;
            mem_s  <= 1'b0;
        end else begin
            iowr_s <= 1'b0;
            mem_s  <= 1'b0;
            case (state)
                zmap_pkg::bus_idle: begin
                    if (io_cond) begin
                        state  <= zmap_pkg::bus_io;
                        iowr_s <= wr;       // reads need no pulse
                    end else if (mem_cond) begin
                        state <= zmap_pkg::bus_mem;
                        mem_s <= 1'b1;
                    end
                end
                zmap_pkg::bus_io: begin
                    if (!io_cond)
                        state <= zmap_pkg::bus_idle;
                end
                zmap_pkg::bus_mem: begin
                    if (!mem_cond)
                        state <= zmap_pkg::bus_idle;
                end
                default: state <= zmap_pkg::bus_idle;
            endcase
        end
    end

    assign bus.a      = a_s2;
    assign bus.d      = d_s2;
    assign bus.rd     = rd;
    assign bus.wr     = wr;
    assign bus.iord   = iorq & rd;
    assign bus.iowr_s = iowr_s;
    assign bus.mem_s  = mem_s;

endmodule

// File: zmap/page_window.sv
`timescale 1ns/100ps
`include "zmap_settings.svh"

module page_window #(
    parameter int WIN = 0       // window index
) (
    input  logic            fclk,
    input  logic            arst_n,
    zbus_if.client          bus,
    output zmap_pkg::page_t page,
    output logic            win_hit,
    output logic            port_hit
);

    localparam logic [7:0] PORT_HI = 8'(`ZMAP_PORT_HI_BASE + WIN);
    localparam zmap_pkg::win_sel_t WIN_SEL = zmap_pkg::win_sel_t'(WIN);
    localparam zmap_pkg::page_t PAGE_RST = zmap_pkg::page_t'(WIN);

    logic page_we;

    // full 16-bit decode of the page port
    assign port_hit = (bus.a[7:0] == `ZMAP_PORT_LO) && (bus.a[15:8] == PORT_HI);

    assign page_we = bus.iowr_s & port_hit;

    always_ff @(posedge fclk or negedge arst_n) begin
        if (!arst_n)
            page <= PAGE_RST;    // window i starts on page i
        else if (page_we)
            page <= zmap_pkg::page_t'(bus.d);
    end

    assign win_hit = (bus.a[15:14] == WIN_SEL);

endmodule

// File: zmap/zmap_mux.sv
`timescale 1ns/100ps
`include "zmap_settings.svh"

module zmap_mux (
    input  logic              fclk,
    input  logic              arst_n,
    zbus_if.client            bus,
    input  logic              win_hit [`ZMAP_WINDOWS],
    input  zmap_pkg::page_t   win_page [`ZMAP_WINDOWS],
    input  logic              port_hit [`ZMAP_WINDOWS],
    output zmap_pkg::zdata_t  d_out,
    output logic              d_oe,
    output zmap_pkg::daddr_t  dram_addr,
    output logic              dram_req,
    output logic              dram_rnw,
    output zmap_pkg::bsel_t   dram_bsel
);

    zmap_pkg::page_t mem_page;
    zmap_pkg::page_t rd_page;
    logic any_port;

    // hits are one-hot, so an or-mux is enough
    always_comb begin
        mem_page = '0;
        rd_page  = '0;
        any_port = 1'b0;
        for (int i = 0; i < `ZMAP_WINDOWS; i++) begin
            if (win_hit[i])
                mem_page = mem_page | win_page[i];
            if (port_hit[i]) begin
                rd_page  = rd_page | win_page[i];
                any_port = 1'b1;
            end
        end
    end

    assign d_out = zmap_pkg::zdata_t'(rd_page);
    assign d_oe  = bus.iord & any_port;

    always_ff @(posedge fclk or negedge arst_n) begin
        if (!arst_n)
            dram_req <= 1'b0;
        else
            dram_req <= bus.mem_s;  // one pulse per memory cycle
    end

    // word address plus byte lane, held until the next cycle
    always_ff @(posedge fclk) begin
        if (bus.mem_s) begin
            dram_addr <= {mem_page, bus.a[13:1]};
            dram_rnw  <= bus.rd;
            dram_bsel <= {bus.a[0], ~bus.a[0]};
        end
    end

endmodule

// File: design/zmap_top.sv
`timescale 1ns/100ps
`include "zmap_settings.svh"

module zmap_top (
    input  logic             fclk,
    input  logic             arst_n,

    // z80
    input  logic             iorq_n,
    input  logic             mreq_n,
    input  logic             rd_n,
    input  logic             wr_n,
    input  zmap_pkg::zaddr_t a,
    input  zmap_pkg::zdata_t d_in,
    output zmap_pkg::zdata_t d_out,
    output logic             d_oe,

    // dram request
    output zmap_pkg::daddr_t dram_addr,
    output logic             dram_req,
    output logic             dram_rnw,
    output zmap_pkg::bsel_t  dram_bsel
);

    zbus_if bus ();

    logic            win_hit [`ZMAP_WINDOWS];
    zmap_pkg::page_t win_page [`ZMAP_WINDOWS];
    logic            port_hit [`ZMAP_WINDOWS];

    zsignals zsignals (
        .fclk   (fclk),
        .arst_n (arst_n),
        .iorq_n (iorq_n),
        .mreq_n (mreq_n),
        .rd_n   (rd_n),
        .wr_n   (wr_n),
        .a      (a),
        .d_in   (d_in),
        .bus    (bus.decoder)
    );

    // ports #10AF..#13AF
    for (genvar i = 0; i < `ZMAP_WINDOWS; i++) begin : g_win
        page_window #(
            .WIN (i)
        ) page_window (
            .fclk     (fclk),
            .arst_n   (arst_n),
            .bus      (bus.client),
            .page     (win_page[i]),
            .win_hit  (win_hit[i]),
            .port_hit (port_hit[i])
        );
    end

    zmap_mux zmap_mux (
        .fclk      (fclk),
        .arst_n    (arst_n),
        .bus       (bus.client),
        .win_hit   (win_hit),
        .win_page  (win_page),
        .port_hit  (port_hit),
        .d_out     (d_out),
        .d_oe      (d_oe),
        .dram_addr (dram_addr),
        .dram_req  (dram_req),
        .dram_rnw  (dram_rnw),
        .dram_bsel (dram_bsel)
    );

endmodule

// File: bench/zmap_properties.sv
`timescale 1ns/100ps

module zmap_properties (
    input logic fclk,
    input logic arst_n,
    input logic iorq_n,
    input logic d_oe,
    input logic dram_req
);

    int fail_count = 0;     // read by the testbench at the end

    // bus is released right after reset
    a_oe_after_reset: assert property (
        @(posedge fclk) $rose(arst_n) |-> !d_oe
    ) else begin
        $error("d_oe high in the first cycle after reset");
        fail_count++;
    end

    a_req_single: assert property (
        @(posedge fclk) disable iff (!arst_n) dram_req |=> !dram_req
    ) else begin
        $error("dram_req held for two cycles");
        fail_count++;
    end

    // two sync stages, so three idle samples are enough
    a_oe_needs_iorq: assert property (
        @(posedge fclk) disable iff (!arst_n)
        (iorq_n && $past(iorq_n) && $past(iorq_n, 2)) |-> !d_oe
    ) else begin
        $error("d_oe high without an io cycle");
        fail_count++;
    end

endmodule

bind zmap_top zmap_properties props (
    .fclk     (fclk),
    .arst_n   (arst_n),
    .iorq_n   (iorq_n),
    .d_oe     (d_oe),
    .dram_req (dram_req)
);

// File: bench/tb_zmap.sv
`timescale 1ns/100ps
`include "zmap_settings.svh"

module tb_zmap;

    localparam int TIMEOUT = 20;    // cycles

    logic             fclk;
    logic             arst_n;
    logic             iorq_n;
    logic             mreq_n;
    logic             rd_n;
    logic             wr_n;
    zmap_pkg::zaddr_t a;
    zmap_pkg::zdata_t d_in;
    zmap_pkg::zdata_t d_out;
    logic             d_oe;
    zmap_pkg::daddr_t dram_addr;
    logic             dram_req;
    logic             dram_rnw;
    zmap_pkg::bsel_t  dram_bsel;

    zmap_pkg::page_t exp_page [`ZMAP_WINDOWS];   // expected page per window
    integer seed = 32'h867d_0b93;
    int value_errors = 0;
    int timeout_errors = 0;

    zmap_top UUT (
        .fclk      (fclk),
        .arst_n    (arst_n),
        .iorq_n    (iorq_n),
        .mreq_n    (mreq_n),
        .rd_n      (rd_n),
        .wr_n      (wr_n),
        .a         (a),
        .d_in      (d_in),
        .d_out     (d_out),
        .d_oe      (d_oe),
        .dram_addr (dram_addr),
        .dram_req  (dram_req),
        .dram_rnw  (dram_rnw),
        .dram_bsel (dram_bsel)
    );

    always #5 fclk = ~fclk;

    function automatic zmap_pkg::zaddr_t page_port(input int win);
        return {8'(`ZMAP_PORT_HI_BASE + win), 8'(`ZMAP_PORT_LO)};
    endfunction

    task automatic idle(input int n);
        repeat (n) @(posedge fclk);
    endtask

    task automatic io_write(input zmap_pkg::zaddr_t addr, input zmap_pkg::zdata_t data);
        int win;
        win = int'(addr[15:8]) - int'(`ZMAP_PORT_HI_BASE);
        @(posedge fclk);
        a      <= addr;
        d_in   <= data;
        iorq_n <= 1'b0;
        wr_n   <= 1'b0;
        idle(8);
        iorq_n <= 1'b1;
        wr_n   <= 1'b1;
        idle(4);    // fsm back to idle
        if (addr[7:0] == `ZMAP_PORT_LO && win >= 0 && win < `ZMAP_WINDOWS)
            exp_page[zmap_pkg::win_sel_t'(win)] = data;
    endtask

    task automatic io_read(input zmap_pkg::zaddr_t addr, output zmap_pkg::zdata_t data);
        int n;
        @(posedge fclk);
        a      <= addr;
        iorq_n <= 1'b0;
        rd_n   <= 1'b0;
        n = 0;
        do begin
            @(negedge fclk);
            n++;
        end while (!d_oe && n < TIMEOUT);
        assert (d_oe) else begin
            timeout_errors++;
            $display("no d_oe within %0d cycles of reading port %h", TIMEOUT, addr);
        end
        idle(4);
        @(negedge fclk);
        data = d_out;
        @(posedge fclk);
        iorq_n <= 1'b1;
        rd_n   <= 1'b1;
        n = 0;
        do begin
            @(negedge fclk);
            n++;
        end while (d_oe && n < TIMEOUT);
        assert (!d_oe) else begin
            timeout_errors++;
            $display("d_oe still high %0d cycles after reading port %h", TIMEOUT, addr);
        end
        idle(2);
    endtask

    task automatic mem_cycle(input zmap_pkg::zaddr_t addr, input logic is_read);
        zmap_pkg::daddr_t exp_addr;
        zmap_pkg::bsel_t  exp_bsel;
        int n;
        int pulses;
        exp_addr = {exp_page[addr[15:14]], addr[13:1]};
        exp_bsel = addr[0] ? 2'b10 : 2'b01;   // odd address is the high byte
        @(posedge fclk);
        a      <= addr;
        mreq_n <= 1'b0;
        rd_n   <= !is_read;
        wr_n   <= is_read;
        n = 0;
        pulses = 0;
        do begin
            @(negedge fclk);
            n++;
            assert (!d_oe) else begin
                value_errors++;
                $display("Fail %0t: d_oe high in memory cycle at %h", $time, addr);
            end
        end while (!dram_req && n < TIMEOUT);
        assert (dram_req) else begin
            timeout_errors++;
            $display("no dram_req within %0d cycles of memory cycle at %h", TIMEOUT, addr);
        end
        if (dram_req) begin
            pulses = 1;
            assert (dram_addr == exp_addr && dram_rnw == is_read && dram_bsel == exp_bsel)
            else begin
                value_errors++;
                $display("Fail %0t: a=%h got %h/%b/%b, expected %h/%b/%b", $time, addr,
                         dram_addr, dram_rnw, dram_bsel, exp_addr, is_read, exp_bsel);
            end
        end
        repeat (6) begin
            @(negedge fclk);
            if (dram_req)
                pulses++;
        end
        @(posedge fclk);
        mreq_n <= 1'b1;
        rd_n   <= 1'b1;
        wr_n   <= 1'b1;
        repeat (4) begin
            @(negedge fclk);
            if (dram_req)
                pulses++;
        end
        assert (pulses == 1) else begin
            value_errors++;
            $display("Fail %0t: %0d dram_req pulses for cycle at %h", $time, pulses, addr);
        end
    endtask

    task automatic after_reset();
        zmap_pkg::zdata_t got;
        for (int i = 0; i < `ZMAP_WINDOWS; i++) begin
            io_read(page_port(i), got);
            assert (got == 8'(i)) else begin
                value_errors++;
                $display("Fail %0t: window %0d reset page %h", $time, i, got);
            end
        end
    endtask

    task automatic page_roundtrip();
        zmap_pkg::zdata_t got;
        zmap_pkg::zdata_t lo;
        zmap_pkg::zaddr_t addr;
        for (int i = 0; i < `ZMAP_WINDOWS; i++)
            io_write(page_port(i), 8'($random(seed)));
        // same high byte, wrong low byte
        for (int i = 0; i < `ZMAP_WINDOWS; i++) begin
            lo = 8'($random(seed));
            if (lo == `ZMAP_PORT_LO)
                lo = 8'h00;
            addr = page_port(i);
            addr[7:0] = lo;
            io_write(addr, 8'($random(seed)));
        end
        for (int i = 0; i < `ZMAP_WINDOWS; i++) begin
            io_read(page_port(i), got);
            assert (got == exp_page[zmap_pkg::win_sel_t'(i)]) else begin
                value_errors++;
                $display("Fail %0t: window %0d read %h, expected %h", $time, i, got,
                         exp_page[zmap_pkg::win_sel_t'(i)]);
            end
        end
    endtask

    task automatic read_translation();
        for (int i = 0; i < `ZMAP_WINDOWS; i++)
            mem_cycle({2'(i), 14'($random(seed))}, 1'b1);
    endtask

    task automatic write_lanes();
        zmap_pkg::zaddr_t addr;
        for (int i = 0; i < `ZMAP_WINDOWS; i++) begin
            addr = {2'(i), 14'($random(seed))};
            mem_cycle({addr[15:1], 1'b0}, 1'b0);
            mem_cycle({addr[15:1], 1'b1}, 1'b0);
        end
    endtask

    task automatic single_rewrite();
        zmap_pkg::zdata_t data;
        data = 8'($random(seed));
        if (data == exp_page[2])
            data = ~data;   // page must really change
        io_write(page_port(2), data);
        for (int i = 0; i < `ZMAP_WINDOWS; i++)
            mem_cycle({2'(i), 14'($random(seed))}, 1'b1);
    endtask

    initial begin
        fclk   = 1'b0;
        arst_n = 1'b0;
        iorq_n = 1'b1;
        mreq_n = 1'b1;
        rd_n   = 1'b1;
        wr_n   = 1'b1;
        a      = '0;
        d_in   = '0;
        for (int i = 0; i < `ZMAP_WINDOWS; i++)
            exp_page[zmap_pkg::win_sel_t'(i)] = zmap_pkg::page_t'(i);
        repeat (3) @(posedge fclk);
        arst_n <= 1'b1;
        idle(2);

        after_reset();
        page_roundtrip();
        read_translation();
        write_lanes();
        single_rewrite();

        $display("errors: %0d value, %0d timeout, %0d assertion", value_errors,
                 timeout_errors, UUT.props.fail_count);
        if (value_errors + timeout_errors + UUT.props.fail_count == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+common
common/zmap_pkg.sv
common/zbus_if.sv
design/zsignals.sv
zmap/page_window.sv
zmap/zmap_mux.sv
design/zmap_top.sv
bench/zmap_properties.sv
bench/tb_zmap.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_zmap
RTL_TOP  = zmap_top
FILELIST = vlog.f
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --assert -f $(FILELIST) --top-module $(RTL_TOP)

# pass only if the log holds the pass line
sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
